// ==== hw/rs_alu_pipe.sv ====
`default_nettype none

module rs_alu_pipe
  import rs_pkg::*;
#(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_iss_valid,
  input  alu_op_t               i_iss_op,
  input  preg_t                 i_iss_rd,
  input  preg_t                 i_iss_rs1,
  input  preg_t                 i_iss_rs2,
  input  xdata_t                i_iss_imm,
  input  logic [ENTRY_SIZE-1:0] i_iss_index_oh,
  output preg_t                 o_rd_tag1,
  output preg_t                 o_rd_tag2,
  input  xdata_t                i_rd_data1,
  input  xdata_t                i_rd_data2,
  output logic                  o_wb_valid,
  output preg_t                 o_wb_tag,
  output xdata_t                o_wb_data,
  output logic [ENTRY_SIZE-1:0] o_wb_index_oh
);

  logic                  r_s1_valid;
  alu_op_t               r_s1_op;
  preg_t                 r_s1_rd;
  xdata_t                r_s1_imm;
  logic [ENTRY_SIZE-1:0] r_s1_index_oh;
  xdata_t                w_result;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      o_wb_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_iss_valid;
      o_wb_valid <= r_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_op       <= i_iss_op;
    r_s1_rd       <= i_iss_rd;
    o_rd_tag1     <= i_iss_rs1;  // Operand read in stage 1.
    o_rd_tag2     <= i_iss_rs2;
    r_s1_imm      <= i_iss_imm;
    r_s1_index_oh <= i_iss_index_oh;
    o_wb_tag      <= r_s1_rd;
    o_wb_data     <= w_result;
    o_wb_index_oh <= r_s1_index_oh;
  end

  always_comb begin
    case (r_s1_op)
      ALU_SUB:  w_result = i_rd_data1 - i_rd_data2;
      ALU_AND:  w_result = i_rd_data1 & i_rd_data2;
      ALU_OR:   w_result = i_rd_data1 | i_rd_data2;
      ALU_XOR:  w_result = i_rd_data1 ^ i_rd_data2;
      ALU_SLL:  w_result = i_rd_data1 << i_rd_data2[SHAMT_W-1:0];
      ALU_ADDI: w_result = i_rd_data1 + r_s1_imm;
      ALU_LUI:  w_result = {r_s1_imm[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
      default:  w_result = i_rd_data1 + i_rd_data2;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rs_inst_decode.sv ====
`default_nettype none

module rs_inst_decode
  import rs_pkg::*;
#(
  parameter int IN_PORT_SIZE = 2
) (
  input  logic [IN_PORT_SIZE-1:0] i_disp_valid,
  input  inst_word_t              i_disp_inst[IN_PORT_SIZE],
  input  logic [PREG_NUM-1:0]     i_busy,
  input  logic                    i_wb_valid,
  input  preg_t                   i_wb_tag,
  output logic [IN_PORT_SIZE-1:0] o_valid,
  output alu_op_t                 o_op[IN_PORT_SIZE],
  output preg_t                   o_rd[IN_PORT_SIZE],
  output preg_t                   o_rs1[IN_PORT_SIZE],
  output preg_t                   o_rs2[IN_PORT_SIZE],
  output logic [IN_PORT_SIZE-1:0] o_rs1_rdy,
  output logic [IN_PORT_SIZE-1:0] o_rs2_rdy,
  output xdata_t                  o_imm[IN_PORT_SIZE],
  output grp_id_t                 o_grp_id[IN_PORT_SIZE]
);

  logic [OPC_W-1:0]        w_opc[IN_PORT_SIZE];
  logic [IN_PORT_SIZE-1:0] w_rs1_used;
  logic [IN_PORT_SIZE-1:0] w_rs2_used;

  assign o_valid = i_disp_valid;

  for (genvar p = 0; p < IN_PORT_SIZE; p++) begin : g_port
    assign w_opc[p]    = i_disp_inst[p][OPC_LSB +: OPC_W];
    assign o_op[p]     = w_opc[p][OPC_W-1] ? ALU_ADD : alu_op_t'(w_opc[p][2:0]);
    assign o_rd[p]     = i_disp_inst[p][RD_LSB +: PREG_W];
    assign o_rs1[p]    = i_disp_inst[p][RS1_LSB +: PREG_W];
    assign o_rs2[p]    = i_disp_inst[p][RS2_LSB +: PREG_W];
    assign o_imm[p]    = {{(XLEN-IMM_W){i_disp_inst[p][IMM_W-1]}}, i_disp_inst[p][IMM_W-1:0]};
    assign o_grp_id[p] = grp_id_t'(1 << p);
    assign w_rs1_used[p] = (o_op[p] != ALU_LUI);
    assign w_rs2_used[p] = (o_op[p] != ALU_LUI) && (o_op[p] != ALU_ADDI);
  end

  // A source waits if it is busy, unless written this cycle, or if an
  // older port of the same group produces it.
  always_comb begin
    for (int p = 0; p < IN_PORT_SIZE; p++) begin
      o_rs1_rdy[p] = !i_busy[o_rs1[p]] || (i_wb_valid && (i_wb_tag == o_rs1[p]));
      o_rs2_rdy[p] = !i_busy[o_rs2[p]] || (i_wb_valid && (i_wb_tag == o_rs2[p]));
      for (int q = 0; q < p; q++) begin
        if (i_disp_valid[q] && (o_rd[q] == o_rs1[p])) begin
          o_rs1_rdy[p] = 1'b0;
        end
        if (i_disp_valid[q] && (o_rd[q] == o_rs2[p])) begin
          o_rs2_rdy[p] = 1'b0;
        end
      end
      o_rs1_rdy[p] = o_rs1_rdy[p] || !w_rs1_used[p];
      o_rs2_rdy[p] = o_rs2_rdy[p] || !w_rs2_used[p];
    end
  end

endmodule

`default_nettype wire

// ==== hw/rs_issue_unit.sv ====
`default_nettype none

module rs_issue_unit
  import rs_pkg::*;
#(
  parameter int ENTRY_SIZE   = 8,
  parameter int IN_PORT_SIZE = 2
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [IN_PORT_SIZE-1:0] i_disp_valid,
  input  inst_word_t              i_disp_inst[IN_PORT_SIZE],
  input  cmt_id_t                 i_cmt_id,
  output logic                    o_wb_valid,
  output preg_t                   o_wb_tag,
  output xdata_t                  o_wb_data,
  output logic                    o_done_valid,
  output cmt_id_t                 o_done_cmt_id,
  output grp_id_t                 o_done_grp_id,
  output logic                    o_credit_return
);

  logic [IN_PORT_SIZE-1:0] w_dec_valid;
  alu_op_t                 w_dec_op[IN_PORT_SIZE];
  preg_t                   w_dec_rd[IN_PORT_SIZE];
  preg_t                   w_dec_rs1[IN_PORT_SIZE];
  preg_t                   w_dec_rs2[IN_PORT_SIZE];
  logic [IN_PORT_SIZE-1:0] w_dec_rs1_rdy;
  logic [IN_PORT_SIZE-1:0] w_dec_rs2_rdy;
  xdata_t                  w_dec_imm[IN_PORT_SIZE];
  grp_id_t                 w_dec_grp_id[IN_PORT_SIZE];
  logic [PREG_NUM-1:0]     w_busy;
  logic                    w_iss_valid;
  alu_op_t                 w_iss_op;
  preg_t                   w_iss_rd;
  preg_t                   w_iss_rs1;
  preg_t                   w_iss_rs2;
  xdata_t                  w_iss_imm;
  logic [ENTRY_SIZE-1:0]   w_iss_index_oh;
  preg_t                   w_rd_tag1;
  preg_t                   w_rd_tag2;
  xdata_t                  w_rd_data1;
  xdata_t                  w_rd_data2;
  logic [ENTRY_SIZE-1:0]   w_wb_index_oh;
  logic                    w_sched_done_valid;
  cmt_id_t                 w_sched_done_cmt_id;
  grp_id_t                 w_sched_done_grp_id;

  rs_inst_decode #(.IN_PORT_SIZE(IN_PORT_SIZE)) u_decode (
    .i_disp_valid (i_disp_valid),
    .i_disp_inst  (i_disp_inst),
    .i_busy       (w_busy),
    .i_wb_valid   (o_wb_valid),
    .i_wb_tag     (o_wb_tag),
    .o_valid      (w_dec_valid),
    .o_op         (w_dec_op),
    .o_rd         (w_dec_rd),
    .o_rs1        (w_dec_rs1),
    .o_rs2        (w_dec_rs2),
    .o_rs1_rdy    (w_dec_rs1_rdy),
    .o_rs2_rdy    (w_dec_rs2_rdy),
    .o_imm        (w_dec_imm),
    .o_grp_id     (w_dec_grp_id)
  );

  rs_scheduler #(.ENTRY_SIZE(ENTRY_SIZE), .IN_PORT_SIZE(IN_PORT_SIZE)) u_scheduler (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_valid        (w_dec_valid),
    .i_op           (w_dec_op),
    .i_rd           (w_dec_rd),
    .i_rs1          (w_dec_rs1),
    .i_rs2          (w_dec_rs2),
    .i_rs1_rdy      (w_dec_rs1_rdy),
    .i_rs2_rdy      (w_dec_rs2_rdy),
    .i_imm          (w_dec_imm),
    .i_grp_id       (w_dec_grp_id),
    .i_cmt_id       (i_cmt_id),
    .i_wb_valid     (o_wb_valid),
    .i_wb_tag       (o_wb_tag),
    .i_wb_index_oh  (w_wb_index_oh),
    .o_iss_valid    (w_iss_valid),
    .o_iss_op       (w_iss_op),
    .o_iss_rd       (w_iss_rd),
    .o_iss_rs1      (w_iss_rs1),
    .o_iss_rs2      (w_iss_rs2),
    .o_iss_imm      (w_iss_imm),
    .o_iss_index_oh (w_iss_index_oh),
    .o_done_valid   (w_sched_done_valid),
    .o_done_cmt_id  (w_sched_done_cmt_id),
    .o_done_grp_id  (w_sched_done_grp_id)
  );

  rs_alu_pipe #(.ENTRY_SIZE(ENTRY_SIZE)) u_alu (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_iss_valid    (w_iss_valid),
    .i_iss_op       (w_iss_op),
    .i_iss_rd       (w_iss_rd),
    .i_iss_rs1      (w_iss_rs1),
    .i_iss_rs2      (w_iss_rs2),
    .i_iss_imm      (w_iss_imm),
    .i_iss_index_oh (w_iss_index_oh),
    .o_rd_tag1      (w_rd_tag1),
    .o_rd_tag2      (w_rd_tag2),
    .i_rd_data1     (w_rd_data1),
    .i_rd_data2     (w_rd_data2),
    .o_wb_valid     (o_wb_valid),
    .o_wb_tag       (o_wb_tag),
    .o_wb_data      (o_wb_data),
    .o_wb_index_oh  (w_wb_index_oh)
  );

  rs_result #(.IN_PORT_SIZE(IN_PORT_SIZE)) u_result (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (w_dec_valid),
    .i_disp_rd       (w_dec_rd),
    .i_rd_tag1       (w_rd_tag1),
    .i_rd_tag2       (w_rd_tag2),
    .o_rd_data1      (w_rd_data1),
    .o_rd_data2      (w_rd_data2),
    .i_wb_valid      (o_wb_valid),
    .i_wb_tag        (o_wb_tag),
    .i_wb_data       (o_wb_data),
    .o_busy          (w_busy),
    .i_done_valid    (w_sched_done_valid),
    .i_done_cmt_id   (w_sched_done_cmt_id),
    .i_done_grp_id   (w_sched_done_grp_id),
    .o_done_valid    (o_done_valid),
    .o_done_cmt_id   (o_done_cmt_id),
    .o_done_grp_id   (o_done_grp_id),
    .o_credit_return (o_credit_return)
  );

endmodule

`default_nettype wire

// ==== hw/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

  localparam int XLEN     = 32;
  localparam int PREG_NUM = 32;
  localparam int PREG_W   = $clog2(PREG_NUM);
  localparam int CMT_ID_W = 4;
  localparam int GRP_ID_W = 2;
  localparam int OPC_W    = 4;
  localparam int IMM_W    = 13;
  localparam int SHAMT_W  = 5;

  // Instruction word field positions.
  localparam int OPC_LSB = 28;
  localparam int RD_LSB  = 23;
  localparam int RS1_LSB = 18;
  localparam int RS2_LSB = 13;

  typedef logic [31:0]         inst_word_t;
  typedef logic [PREG_W-1:0]   preg_t;
  typedef logic [XLEN-1:0]     xdata_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;
  typedef logic [GRP_ID_W-1:0] grp_id_t;  // One-hot slot within a dispatch cycle.

  // Encodings follow the opcode field for opcodes 0 to 7.
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLL  = 3'd5,
    ALU_ADDI = 3'd6,
    ALU_LUI  = 3'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    ENTRY_FREE   = 2'd0,
    ENTRY_WAIT   = 2'd1,
    ENTRY_ISSUED = 2'd2,
    ENTRY_DONE   = 2'd3
  } entry_state_t;

endpackage

`default_nettype wire

// ==== hw/rs_result.sv ====
`default_nettype none

module rs_result
  import rs_pkg::*;
#(
  parameter int IN_PORT_SIZE = 2
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [IN_PORT_SIZE-1:0] i_disp_valid,
  input  preg_t                   i_disp_rd[IN_PORT_SIZE],
  input  preg_t                   i_rd_tag1,
  input  preg_t                   i_rd_tag2,
  output xdata_t                  o_rd_data1,
  output xdata_t                  o_rd_data2,
  input  logic                    i_wb_valid,
  input  preg_t                   i_wb_tag,
  input  xdata_t                  i_wb_data,
  output logic [PREG_NUM-1:0]     o_busy,
  input  logic                    i_done_valid,
  input  cmt_id_t                 i_done_cmt_id,
  input  grp_id_t                 i_done_grp_id,
  output logic                    o_done_valid,
  output cmt_id_t                 o_done_cmt_id,
  output grp_id_t                 o_done_grp_id,
  output logic                    o_credit_return
);

  xdata_t              r_regs[PREG_NUM];
  logic [PREG_NUM-1:0] w_busy_set;
  logic [PREG_NUM-1:0] w_busy_clr;

  always_comb begin
    w_busy_set = '0;
    for (int p = 0; p < IN_PORT_SIZE; p++) begin
      if (i_disp_valid[p]) begin
        w_busy_set[i_disp_rd[p]] = 1'b1;
      end
    end
  end

  assign w_busy_clr = {{(PREG_NUM-1){1'b0}}, i_wb_valid} << i_wb_tag;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < PREG_NUM; i++) begin
        r_regs[i] <= xdata_t'(i);  // Register p starts as p.
      end
    end else if (i_wb_valid) begin
      r_regs[i_wb_tag] <= i_wb_data;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_busy       <= '0;
      o_done_valid <= 1'b0;
    end else begin
      o_busy       <= (o_busy & ~w_busy_clr) | w_busy_set;  // A new producer wins.
      o_done_valid <= i_done_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_done_cmt_id <= i_done_cmt_id;
    o_done_grp_id <= i_done_grp_id;
  end

  assign o_rd_data1      = r_regs[i_rd_tag1];
  assign o_rd_data2      = r_regs[i_rd_tag2];
  assign o_credit_return = o_done_valid;  // One credit per completion.

endmodule

`default_nettype wire

// ==== hw/rs_sched_entry.sv ====
`default_nettype none

module rs_sched_entry
  import rs_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_put,
  input  cmt_id_t i_cmt_id,
  input  grp_id_t i_grp_id,
  input  alu_op_t i_op,
  input  preg_t   i_rd,
  input  preg_t   i_rs1,
  input  preg_t   i_rs2,
  input  logic    i_rs1_rdy,
  input  logic    i_rs2_rdy,
  input  xdata_t  i_imm,
  input  logic    i_wb_valid,
  input  preg_t   i_wb_tag,
  input  logic    i_pipe_done,
  input  logic    i_entry_picked,
  output logic    o_entry_valid,
  output logic    o_entry_ready,
  output alu_op_t o_op,
  output preg_t   o_rd,
  output preg_t   o_rs1,
  output preg_t   o_rs2,
  output xdata_t  o_imm,
  output logic    o_entry_done,
  output cmt_id_t o_cmt_id,
  output grp_id_t o_grp_id
);

  entry_state_t r_state;
  logic         r_rs1_rdy;
  logic         r_rs2_rdy;
  logic         w_rs1_wake;
  logic         w_rs2_wake;

  assign w_rs1_wake = i_wb_valid && (i_wb_tag == o_rs1);
  assign w_rs2_wake = i_wb_valid && (i_wb_tag == o_rs2);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ENTRY_FREE;
    end else begin
      case (r_state)
        ENTRY_FREE, ENTRY_DONE: r_state <= i_put ? ENTRY_WAIT : ENTRY_FREE;
        ENTRY_WAIT:   if (i_entry_picked) r_state <= ENTRY_ISSUED;
        ENTRY_ISSUED: if (i_pipe_done) r_state <= ENTRY_DONE;
        default:      r_state <= ENTRY_FREE;
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rs1_rdy <= 1'b0;
      r_rs2_rdy <= 1'b0;
    end else if (i_put) begin
      r_rs1_rdy <= i_rs1_rdy;
      r_rs2_rdy <= i_rs2_rdy;
    end else begin
      r_rs1_rdy <= r_rs1_rdy | w_rs1_wake;  // Wakeup capture.
      r_rs2_rdy <= r_rs2_rdy | w_rs2_wake;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_put) begin
      o_op     <= i_op;
      o_rd     <= i_rd;
      o_rs1    <= i_rs1;
      o_rs2    <= i_rs2;
      o_imm    <= i_imm;
      o_cmt_id <= i_cmt_id;
      o_grp_id <= i_grp_id;
    end
  end

  // DONE lasts one cycle and may already take a new instruction.
  assign o_entry_valid = (r_state == ENTRY_WAIT) || (r_state == ENTRY_ISSUED);
  assign o_entry_ready = (r_state == ENTRY_WAIT) && r_rs1_rdy && r_rs2_rdy;
  assign o_entry_done  = (r_state == ENTRY_ISSUED) && i_pipe_done;

endmodule

`default_nettype wire

// ==== hw/rs_scheduler.sv ====
`default_nettype none

module rs_scheduler
  import rs_pkg::*;
#(
  parameter int ENTRY_SIZE   = 8,
  parameter int IN_PORT_SIZE = 2
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [IN_PORT_SIZE-1:0] i_valid,
  input  alu_op_t                 i_op[IN_PORT_SIZE],
  input  preg_t                   i_rd[IN_PORT_SIZE],
  input  preg_t                   i_rs1[IN_PORT_SIZE],
  input  preg_t                   i_rs2[IN_PORT_SIZE],
  input  logic [IN_PORT_SIZE-1:0] i_rs1_rdy,
  input  logic [IN_PORT_SIZE-1:0] i_rs2_rdy,
  input  xdata_t                  i_imm[IN_PORT_SIZE],
  input  grp_id_t                 i_grp_id[IN_PORT_SIZE],
  input  cmt_id_t                 i_cmt_id,
  input  logic                    i_wb_valid,
  input  preg_t                   i_wb_tag,
  input  logic [ENTRY_SIZE-1:0]   i_wb_index_oh,
  output logic                    o_iss_valid,
  output alu_op_t                 o_iss_op,
  output preg_t                   o_iss_rd,
  output preg_t                   o_iss_rs1,
  output preg_t                   o_iss_rs2,
  output xdata_t                  o_iss_imm,
  output logic [ENTRY_SIZE-1:0]   o_iss_index_oh,
  output logic                    o_done_valid,
  output cmt_id_t                 o_done_cmt_id,
  output grp_id_t                 o_done_grp_id
);

  logic [ENTRY_SIZE-1:0] w_entry_valid;
  logic [ENTRY_SIZE-1:0] w_entry_ready;
  logic [ENTRY_SIZE-1:0] w_entry_done;
  logic [ENTRY_SIZE-1:0] w_picked_oh;
  logic [ENTRY_SIZE-1:0] w_put_oh[IN_PORT_SIZE];
  alu_op_t               w_entry_op[ENTRY_SIZE];
  preg_t                 w_entry_rd[ENTRY_SIZE];
  preg_t                 w_entry_rs1[ENTRY_SIZE];
  preg_t                 w_entry_rs2[ENTRY_SIZE];
  xdata_t                w_entry_imm[ENTRY_SIZE];
  cmt_id_t               w_entry_cmt_id[ENTRY_SIZE];
  grp_id_t               w_entry_grp_id[ENTRY_SIZE];

  // Each valid port takes the lowest free entry left by the ports before it.
  always_comb begin : alloc
    logic [ENTRY_SIZE-1:0] free_mask;
    free_mask = ~w_entry_valid;
    for (int p = 0; p < IN_PORT_SIZE; p++) begin
      w_put_oh[p] = '0;
      if (i_valid[p]) begin
        w_put_oh[p] = free_mask & (~free_mask + ENTRY_SIZE'(1));
        free_mask   = free_mask & ~w_put_oh[p];
      end
    end
  end

  for (genvar s = 0; s < ENTRY_SIZE; s++) begin : g_entry
    logic    w_put;
    alu_op_t w_op;
    preg_t   w_rd;
    preg_t   w_rs1;
    preg_t   w_rs2;
    logic    w_rs1_rdy;
    logic    w_rs2_rdy;
    xdata_t  w_imm;
    grp_id_t w_grp_id;

    always_comb begin
      w_put     = 1'b0;
      w_op      = ALU_ADD;
      w_rd      = '0;
      w_rs1     = '0;
      w_rs2     = '0;
      w_rs1_rdy = 1'b0;
      w_rs2_rdy = 1'b0;
      w_imm     = '0;
      w_grp_id  = '0;
      for (int p = 0; p < IN_PORT_SIZE; p++) begin
        if (w_put_oh[p][s]) begin
          w_put     = 1'b1;
          w_op      = i_op[p];
          w_rd      = i_rd[p];
          w_rs1     = i_rs1[p];
          w_rs2     = i_rs2[p];
          w_rs1_rdy = i_rs1_rdy[p];
          w_rs2_rdy = i_rs2_rdy[p];
          w_imm     = i_imm[p];
          w_grp_id  = i_grp_id[p];
        end
      end
    end

    rs_sched_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_put          (w_put),
      .i_cmt_id       (i_cmt_id),
      .i_grp_id       (w_grp_id),
      .i_op           (w_op),
      .i_rd           (w_rd),
      .i_rs1          (w_rs1),
      .i_rs2          (w_rs2),
      .i_rs1_rdy      (w_rs1_rdy),
      .i_rs2_rdy      (w_rs2_rdy),
      .i_imm          (w_imm),
      .i_wb_valid     (i_wb_valid),
      .i_wb_tag       (i_wb_tag),
      .i_pipe_done    (i_wb_valid && i_wb_index_oh[s]),
      .i_entry_picked (w_picked_oh[s]),
      .o_entry_valid  (w_entry_valid[s]),
      .o_entry_ready  (w_entry_ready[s]),
      .o_op           (w_entry_op[s]),
      .o_rd           (w_entry_rd[s]),
      .o_rs1          (w_entry_rs1[s]),
      .o_rs2          (w_entry_rs2[s]),
      .o_imm          (w_entry_imm[s]),
      .o_entry_done   (w_entry_done[s]),
      .o_cmt_id       (w_entry_cmt_id[s]),
      .o_grp_id       (w_entry_grp_id[s])
    );
  end

  assign w_picked_oh    = w_entry_ready & (~w_entry_ready + ENTRY_SIZE'(1));  // Lowest set bit.
  assign o_iss_valid    = |w_picked_oh;
  assign o_iss_index_oh = w_picked_oh;
  assign o_done_valid   = |w_entry_done;

  always_comb begin
    o_iss_op      = ALU_ADD;
    o_iss_rd      = '0;
    o_iss_rs1     = '0;
    o_iss_rs2     = '0;
    o_iss_imm     = '0;
    o_done_cmt_id = '0;
    o_done_grp_id = '0;
    for (int s = 0; s < ENTRY_SIZE; s++) begin
      if (w_picked_oh[s]) begin
        o_iss_op  = w_entry_op[s];
        o_iss_rd  = w_entry_rd[s];
        o_iss_rs1 = w_entry_rs1[s];
        o_iss_rs2 = w_entry_rs2[s];
        o_iss_imm = w_entry_imm[s];
      end
      if (w_entry_done[s]) begin
        o_done_cmt_id = w_entry_cmt_id[s];
        o_done_grp_id = w_entry_grp_id[s];
      end
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/rs_pkg.sv
hw/rs_inst_decode.sv
hw/rs_sched_entry.sv
hw/rs_scheduler.sv
hw/rs_alu_pipe.sv
hw/rs_result.sv
hw/rs_issue_unit.sv
test/rs_issue_unit_assertions.sv
test/tb_rs_issue_unit.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_rs_issue_unit -f list.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qF '*** PASSED ***' ||
exit 1

// ==== test/rs_issue_unit_assertions.sv ====
`default_nettype none

module rs_issue_unit_assertions #(
  parameter int ENTRY_SIZE   = 8,
  parameter int IN_PORT_SIZE = 2
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [IN_PORT_SIZE-1:0] i_disp_valid,
  input  logic                    i_iss_valid,
  input  logic [ENTRY_SIZE-1:0]   i_iss_index_oh,
  input  logic [ENTRY_SIZE-1:0]   i_entry_valid,
  input  logic [ENTRY_SIZE-1:0]   i_entry_done
);

  // The issued entry is a single occupied entry.
  a_iss_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_iss_valid |-> $onehot(i_iss_index_oh) && ((i_iss_index_oh & ~i_entry_valid) == '0))
    else $error("Issue index is not one occupied entry while issue is valid");

  // Dispatch never finds the scheduler full.
  a_occupancy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $countones(i_disp_valid) <= $countones(~i_entry_valid))
    else $error("Scheduler occupancy out of range");

  a_single_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $countones(i_entry_done) <= 1)
    else $error("More than one entry completed in one cycle");

endmodule

bind rs_scheduler rs_issue_unit_assertions #(
  .ENTRY_SIZE   (ENTRY_SIZE),
  .IN_PORT_SIZE (IN_PORT_SIZE)
) u_assertions (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_disp_valid   (i_valid),
  .i_iss_valid    (o_iss_valid),
  .i_iss_index_oh (o_iss_index_oh),
  .i_entry_valid  (w_entry_valid),
  .i_entry_done   (w_entry_done)
);

`default_nettype wire

// ==== test/tb_rs_issue_unit.sv ====
`default_nettype none

module tb_rs_issue_unit
  import rs_pkg::*;
();

  localparam int ENTRY_SIZE   = 8;
  localparam int IN_PORT_SIZE = 2;
  localparam int PHASE_LEN    = 16;
  localparam int NUM_PHASES   = 12;
  localparam int TOTAL_INST   = PHASE_LEN * NUM_PHASES;
  localparam int CYCLE_LIMIT  = 40 * TOTAL_INST + 100;

  logic                    i_clk;
  logic                    i_reset_n;
  logic [IN_PORT_SIZE-1:0] i_disp_valid;
  inst_word_t              i_disp_inst[IN_PORT_SIZE];
  cmt_id_t                 i_cmt_id;
  logic                    o_wb_valid;
  preg_t                   o_wb_tag;
  xdata_t                  o_wb_data;
  logic                    o_done_valid;
  cmt_id_t                 o_done_cmt_id;
  grp_id_t                 o_done_grp_id;
  logic                    o_credit_return;

  // Dispatcher and reference model state.
  logic [31:0] lfsr_state;
  int          credits;
  int          dispatched;
  int          end_errors;
  cmt_id_t     cmt_cnt;
  xdata_t      model_regs[PREG_NUM];
  xdata_t      exp_data[PREG_NUM];
  cmt_id_t     exp_cmt[PREG_NUM];
  grp_id_t     exp_grp[PREG_NUM];
  preg_t       dep_tag[PREG_NUM][2];
  logic [1:0]  dep_valid[PREG_NUM];
  int          issued_cnt[PREG_NUM];

  // Comparison state.
  int          written_cnt[PREG_NUM] = '{default: 0};
  int          credit_cnt = 0;
  int          wb_cnt = 0;
  int          value_errors = 0;
  int          flow_errors = 0;
  logic        prev_wb_valid = 1'b0;
  preg_t       prev_wb_tag = '0;
  int          cycles = 0;

  rs_issue_unit #(
    .ENTRY_SIZE   (ENTRY_SIZE),
    .IN_PORT_SIZE (IN_PORT_SIZE)
  ) rs_issue_unit_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (i_disp_valid),
    .i_disp_inst     (i_disp_inst),
    .i_cmt_id        (i_cmt_id),
    .o_wb_valid      (o_wb_valid),
    .o_wb_tag        (o_wb_tag),
    .o_wb_data       (o_wb_data),
    .o_done_valid    (o_done_valid),
    .o_done_cmt_id   (o_done_cmt_id),
    .o_done_grp_id   (o_done_grp_id),
    .o_credit_return (o_credit_return)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic xdata_t ref_result(input logic [3:0] opc, input xdata_t a,
                                        input xdata_t b, input logic [12:0] imm);
    xdata_t simm;
    simm = {{19{imm[12]}}, imm};
    case (opc)
      4'd1:    return a - b;
      4'd2:    return a & b;
      4'd3:    return a | b;
      4'd4:    return a ^ b;
      4'd5:    return a << b[4:0];
      4'd6:    return a + simm;
      4'd7:    return {imm, 19'd0};
      default: return a + b;  // Opcodes above 7 act as ADD.
    endcase
  endfunction

  // Earlier tag of this phase, or a tag of the other half.
  function automatic preg_t pick_src(input int idx, input logic half, input logic force_old);
    preg_t s;
    s = preg_t'(rand_bits(5));
    if (force_old || (s[4] == half && int'(s[3:0]) >= idx)) begin
      s[4] = ~half;
    end
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
    if (o_credit_return) begin
      credits++;
    end
    i_disp_valid = '0;
    i_cmt_id     = cmt_cnt;
  endtask

  task automatic dispatch_one(input int p, input int idx, input logic half,
                              input logic directed);
    logic [3:0]  opc;
    preg_t       rd;
    preg_t       rs1;
    preg_t       rs2;
    logic [12:0] imm;
    opc = directed ? 4'(idx) : 4'(rand_bits(4));
    rs1 = pick_src(idx, half, directed);
    rs2 = pick_src(idx, half, directed);
    imm = 13'(rand_bits(13));
    if (directed) begin
      imm[12] = 1'b1;  // Negative ADDI immediate.
    end
    rd               = {half, 4'(idx)};
    i_disp_inst[p]   = {opc, rd, rs1, rs2, imm};
    i_disp_valid[p]  = 1'b1;
    exp_data[rd]     = ref_result(opc, model_regs[rs1], model_regs[rs2], imm);
    model_regs[rd]   = exp_data[rd];
    exp_cmt[rd]      = cmt_cnt;
    exp_grp[rd]      = grp_id_t'(1 << p);
    dep_tag[rd][0]   = rs1;
    dep_tag[rd][1]   = rs2;
    dep_valid[rd][0] = (rs1[4] == half) && (opc != 4'd7);
    dep_valid[rd][1] = (rs2[4] == half) && (opc != 4'd6) && (opc != 4'd7);
    issued_cnt[rd]++;
    credits--;
    dispatched++;
  endtask

  task automatic run_phase(input int phase);
    int   idx;
    int   want;
    logic half;
    logic directed;
    idx      = 0;
    half     = phase[0];
    directed = (phase == 0);  // Every opcode once, all reading reset values.
    while (idx < PHASE_LEN) begin
      next_cycle();
      want = directed ? IN_PORT_SIZE : int'(rand_bits(2));
      for (int p = 0; p < IN_PORT_SIZE; p++) begin
        if (p < want && credits > 0 && idx < PHASE_LEN) begin
          dispatch_one(p, idx, half, directed);
          idx++;
        end
      end
      if (i_disp_valid != '0) begin
        cmt_cnt = cmt_cnt + 1'b1;
      end
    end
  endtask

  task automatic drain();
    while (credits != ENTRY_SIZE) begin
      next_cycle();
    end
  endtask

  always @(negedge i_clk) begin : compare
    preg_t dep;
    if (i_reset_n) begin
      if (o_wb_valid) begin
        if (issued_cnt[o_wb_tag] == written_cnt[o_wb_tag]) begin
          $display("Writeback to tag %0d with no instruction in flight", o_wb_tag);
          flow_errors++;
        end
        for (int k = 0; k < 2; k++) begin
          dep = dep_tag[o_wb_tag][k];
          if (dep_valid[o_wb_tag][k] && issued_cnt[dep] != written_cnt[dep]) begin
            $display("Tag %0d written back before its producer tag %0d", o_wb_tag, dep);
            flow_errors++;
          end
        end
        check_value("o_wb_data", o_wb_data, exp_data[o_wb_tag]);
        written_cnt[o_wb_tag]++;
        wb_cnt++;
      end
      check_value("o_done_valid", 32'(o_done_valid), 32'(prev_wb_valid));
      if (o_done_valid && prev_wb_valid) begin
        check_value("o_done_cmt_id", 32'(o_done_cmt_id), 32'(exp_cmt[prev_wb_tag]));
        check_value("o_done_grp_id", 32'(o_done_grp_id), 32'(exp_grp[prev_wb_tag]));
      end
      check_value("o_credit_return", 32'(o_credit_return), 32'(prev_wb_valid));
      if (o_credit_return) begin
        credit_cnt++;
      end
      prev_wb_valid = o_wb_valid;
      prev_wb_tag   = o_wb_tag;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    lfsr_state   = 32'haa66_3646;
    i_reset_n    = 1'b0;
    i_disp_valid = '0;
    i_cmt_id     = '0;
    for (int p = 0; p < IN_PORT_SIZE; p++) begin
      i_disp_inst[p] = '0;
    end
    credits    = ENTRY_SIZE;
    dispatched = 0;
    end_errors = 0;
    cmt_cnt    = '0;
    for (int t = 0; t < PREG_NUM; t++) begin
      model_regs[t] = xdata_t'(t);  // Reset value of register p is p.
      exp_data[t]   = '0;
      exp_cmt[t]    = '0;
      exp_grp[t]    = '0;
      dep_valid[t]  = '0;
      issued_cnt[t] = 0;
    end
    repeat (16) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    repeat (10) next_cycle();  // Idle, nothing may come out.
    for (int ph = 0; ph < NUM_PHASES; ph++) begin
      run_phase(ph);
      drain();
    end
    repeat (4) next_cycle();
    if (credit_cnt != dispatched || wb_cnt != dispatched) begin
      $display("Counts differ: %0d dispatched, %0d credits returned, %0d writebacks",
               dispatched, credit_cnt, wb_cnt);
      end_errors++;
    end
    for (int t = 0; t < PREG_NUM; t++) begin
      if (issued_cnt[t] != written_cnt[t]) begin
        $display("Tag %0d dispatched %0d times but written back %0d times",
                 t, issued_cnt[t], written_cnt[t]);
        end_errors++;
      end
    end
    $display("Errors: %0d value, %0d flow, %0d end of run",
             value_errors, flow_errors, end_errors);
    if (value_errors + flow_errors + end_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
